// ==== pat_pkg.sv ====
package pat_pkg;

	// ==============================
	// widths
	// ==============================
	localparam int instr_width = 20; // one instruction word per cycle
	localparam int data_width = 8; // accumulator and memory word
	localparam int dmem_depth = 16;
	localparam int dmem_adr_width = $clog2(dmem_depth); // low immediate bits

	// opcode value that escapes i8 -> i3 and i3 -> i0
	localparam logic [3:0] prefix_ext = 4'b1111;

	// ==============================
	// opcodes
	// ==============================
	// i8 group
	localparam logic [3:0] op8_or = 4'b0000;
	localparam logic [3:0] op8_and = 4'b0001;
	localparam logic [3:0] op8_addm = 4'b0010;
	localparam logic [3:0] op8_subm = 4'b0011;
	localparam logic [3:0] op8_add = 4'b0100;
	localparam logic [3:0] op8_sub = 4'b0101;
	localparam logic [3:0] op8_ldi = 4'b0110;
	localparam logic [3:0] op8_ldm = 4'b0111;
	localparam logic [3:0] op8_stm = 4'b1011;
	localparam logic [3:0] op8_orm = 4'b1101;
	localparam logic [3:0] op8_andm = 4'b1110;
	// i3 group, sub-opcode after the first prefix
	localparam logic [3:0] op3_shl = 4'b0000;
	localparam logic [3:0] op3_shlo = 4'b0001;
	localparam logic [3:0] op3_shr = 4'b0010;
	localparam logic [3:0] op3_asr = 4'b0011;
	localparam logic [3:0] op3_in = 4'b0101;
	localparam logic [3:0] op3_out = 4'b1000;
	// i0 group, after both prefixes
	localparam logic [3:0] op0_not = 4'b0000;
	localparam logic [3:0] op0_test = 4'b0010;
	localparam logic [3:0] op0_nop = 4'b1111;

	localparam logic [instr_width-1:0] instr_nop = 20'h06ff5; // cond 11, i0 slot unlisted

	typedef logic [data_width-1:0] data_t;

	// i8 view of the word
	typedef struct packed {
		logic [4:0] ptr; // field pointer, ignored by this core
		logic [1:0] cond;
		logic field; // field-op flag, ignored
		logic [3:0] opcode;
		logic [7:0] imm8;
	} instr_i8_t;

	// prefixed view, i3 opcode then i0 opcode / 3-bit immediate
	typedef struct packed {
		logic [11:0] upper; // holds the i8 prefix
		logic [3:0] opcode_i3;
		logic [3:0] low; // i0 opcode; imm3 in [2:0]
	} instr_ext_t;

	typedef union packed {
		instr_i8_t i8;
		instr_ext_t ext;
	} instr_u;

	typedef enum logic [3:0] {
		alu_or, alu_and, alu_add, alu_sub, alu_not,
		alu_shl, alu_shlo, alu_shr, alu_asr, alu_pass_b
	} alu_fn_e;

	typedef struct packed {
		logic [1:0] cond;
		alu_fn_e alu_fn;
		data_t operand_b; // memory word or immediate, already muxed
		logic src_in; // acc takes i_inputs
		logic wr_acc;
		logic wr_mem;
		logic wr_out;
		logic set_flags;
		logic [dmem_adr_width-1:0] mem_adr;
	} ctrl_t;

	typedef struct packed {
		logic z;
		logic n;
	} flags_t;

endpackage

// ==== pat_decode.sv ====
module pat_decode (
	input logic clk,
	input logic reset,
	input pat_pkg::instr_u i_instruction,
	output logic [pat_pkg::dmem_adr_width-1:0] o_dmem_adr,
	input pat_pkg::data_t i_dmem_data,
	output pat_pkg::ctrl_t o_ctrl
);

	pat_pkg::instr_u instr_q; // stage 1 instruction register
	pat_pkg::ctrl_t ctrl_d;
	pat_pkg::data_t imm; // zero-extended immediate
	logic is_i8;
	logic is_i3; // i0 is whatever is left
	logic use_mem; // memory-operand op

	always_ff @(posedge clk)
	begin
		if (reset)
			instr_q <= pat_pkg::instr_nop;
		else
			instr_q <= i_instruction;
	end

	// format from the nested prefixes
	assign is_i8 = (instr_q.i8.opcode != pat_pkg::prefix_ext);
	assign is_i3 = !is_i8 && (instr_q.ext.opcode_i3 != pat_pkg::prefix_ext);

	assign imm = is_i8 ? instr_q.i8.imm8 : {5'b0, instr_q.ext.low[2:0]};
	assign o_dmem_adr = instr_q.i8.imm8[pat_pkg::dmem_adr_width-1:0]; // read in this stage
	assign use_mem = is_i8 && (instr_q.i8.opcode inside {pat_pkg::op8_ldm, pat_pkg::op8_addm,
		pat_pkg::op8_subm, pat_pkg::op8_orm, pat_pkg::op8_andm});

	// ==============================
	// control word
	// ==============================
	always_comb
	begin
		ctrl_d = '0; // nop unless an opcode below says otherwise
		ctrl_d.cond = instr_q.i8.cond; // cond sits in the same bits for all formats
		ctrl_d.alu_fn = pat_pkg::alu_pass_b;
		ctrl_d.operand_b = use_mem ? i_dmem_data : imm;
		ctrl_d.mem_adr = o_dmem_adr; // also the stm target
		if (is_i8)
		begin
			ctrl_d.wr_acc = 1'b1; // nearly every i8 op lands in acc
			case (instr_q.i8.opcode)
				pat_pkg::op8_or, pat_pkg::op8_orm: ctrl_d.alu_fn = pat_pkg::alu_or;
				pat_pkg::op8_and, pat_pkg::op8_andm: ctrl_d.alu_fn = pat_pkg::alu_and;
				pat_pkg::op8_add, pat_pkg::op8_addm: ctrl_d.alu_fn = pat_pkg::alu_add;
				pat_pkg::op8_sub, pat_pkg::op8_subm: ctrl_d.alu_fn = pat_pkg::alu_sub;
				pat_pkg::op8_ldi, pat_pkg::op8_ldm: ctrl_d.alu_fn = pat_pkg::alu_pass_b;
				pat_pkg::op8_stm:
				begin
					ctrl_d.wr_acc = 1'b0; // store leaves acc alone
					ctrl_d.wr_mem = 1'b1;
				end
				default: ctrl_d.wr_acc = 1'b0; // old branch/call slots, nop
			endcase
		end
		else if (is_i3)
		begin
			ctrl_d.wr_acc = 1'b1;
			case (instr_q.ext.opcode_i3)
				pat_pkg::op3_shl: ctrl_d.alu_fn = pat_pkg::alu_shl;
				pat_pkg::op3_shlo: ctrl_d.alu_fn = pat_pkg::alu_shlo;
				pat_pkg::op3_shr: ctrl_d.alu_fn = pat_pkg::alu_shr;
				pat_pkg::op3_asr: ctrl_d.alu_fn = pat_pkg::alu_asr;
				pat_pkg::op3_in: ctrl_d.src_in = 1'b1; // acc <- i_inputs
				pat_pkg::op3_out:
				begin
					ctrl_d.wr_acc = 1'b0;
					ctrl_d.wr_out = 1'b1;
				end
				default: ctrl_d.wr_acc = 1'b0;
			endcase
		end
		else
		begin
			case (instr_q.ext.low)
				pat_pkg::op0_not:
				begin
					ctrl_d.alu_fn = pat_pkg::alu_not;
					ctrl_d.wr_acc = 1'b1;
				end
				pat_pkg::op0_test: ctrl_d.set_flags = 1'b1;
				pat_pkg::op0_nop: ; // nothing to commit
				default: ; // unlisted i0 codes behave as nop
			endcase
		end
	end

	// payload loads every cycle, reset only clears the write bits
	always_ff @(posedge clk)
	begin
		o_ctrl <= ctrl_d;
		if (reset)
		begin
			o_ctrl.src_in <= 1'b0;
			o_ctrl.wr_acc <= 1'b0;
			o_ctrl.wr_mem <= 1'b0;
			o_ctrl.wr_out <= 1'b0;
			o_ctrl.set_flags <= 1'b0;
		end
	end

	// acc and memory are never both targets of one instruction
	a_acc_mem_excl: assert property (@(posedge clk) disable iff (reset)
		!(o_ctrl.wr_acc && o_ctrl.wr_mem));

endmodule

// ==== pat_data_mem.sv ====
module pat_data_mem (
	input logic clk,
	input logic [pat_pkg::dmem_adr_width-1:0] i_rd_adr,
	output pat_pkg::data_t o_rd_data,
	input logic i_wr_en,
	input logic [pat_pkg::dmem_adr_width-1:0] i_wr_adr,
	input pat_pkg::data_t i_wr_data
);

	pat_pkg::data_t mem [pat_pkg::dmem_depth]; // contents undefined until written

	// ==============================
	// read / write
	// ==============================
	assign o_rd_data = mem[i_rd_adr]; // async read, decode stage

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[i_wr_adr] <= i_wr_data; // commit stage write
	end

	// the commit stage must hand over a clean address with every write
	a_wr_adr_known: assert property (@(posedge clk)
		i_wr_en |-> !$isunknown(i_wr_adr));

endmodule

// ==== pat_alu.sv ====
module pat_alu (
	input pat_pkg::alu_fn_e i_fn,
	input pat_pkg::data_t i_a, // committed accumulator
	input pat_pkg::data_t i_b, // memory word or immediate
	output pat_pkg::data_t o_y
);

	logic [2:0] sh; // shift distance from the i3 immediate
	pat_pkg::data_t ones_fill; // low bits vacated by shlo

	assign sh = i_b[2:0];
	assign ones_fill = ~({pat_pkg::data_width{1'b1}} << sh);

	// ==============================
	// function select
	// ==============================
	always_comb
	begin
		case (i_fn)
			pat_pkg::alu_or:
				o_y = i_a | i_b;
			pat_pkg::alu_and:
				o_y = i_a & i_b;
			pat_pkg::alu_add:
				o_y = i_a + i_b; // wraps at 8 bits
			pat_pkg::alu_sub:
				o_y = i_a - i_b;
			pat_pkg::alu_not:
				o_y = ~i_a;
			pat_pkg::alu_shl:
				o_y = i_a << sh;
			pat_pkg::alu_shlo:
				o_y = (i_a << sh) | ones_fill; // ones shifted in
			pat_pkg::alu_shr:
				o_y = i_a >> sh;
			pat_pkg::alu_asr:
				o_y = pat_pkg::data_t'($signed(i_a) >>> sh); // sign kept
			pat_pkg::alu_pass_b:
				o_y = i_b; // ldi, ldm
			default:
				o_y = i_b;
		endcase
	end

endmodule

// ==== pat_commit.sv ====
module pat_commit (
	input logic clk,
	input logic reset,
	input pat_pkg::ctrl_t i_ctrl,
	input pat_pkg::data_t i_alu_y,
	input pat_pkg::data_t i_inputs,
	output pat_pkg::data_t o_acc,
	output pat_pkg::data_t o_outputs,
	output logic o_wr_en,
	output logic [pat_pkg::dmem_adr_width-1:0] o_wr_adr,
	output pat_pkg::data_t o_wr_data
);

	pat_pkg::flags_t flags_q; // z / n, only test updates them
	logic cond_ok;

	// ==============================
	// condition check
	// ==============================
	always_comb
	begin
		case (i_ctrl.cond)
			2'b00: cond_ok = flags_q.z; // if zero
			2'b01: cond_ok = flags_q.n; // if negative
			default: cond_ok = 1'b1; // always
		endcase
	end

	// memory write goes straight to the RAM edge, no extra register
	assign o_wr_en = i_ctrl.wr_mem && cond_ok;
	assign o_wr_adr = i_ctrl.mem_adr;
	assign o_wr_data = o_acc; // stm stores the committed acc

	// ==============================
	// architectural state
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc <= '0;
			o_outputs <= '0;
			flags_q <= '0;
		end
		else if (cond_ok)
		begin
			if (i_ctrl.wr_acc)
				o_acc <= i_ctrl.src_in ? i_inputs : i_alu_y;
			if (i_ctrl.wr_out)
				o_outputs <= o_acc; // held until the next out
			if (i_ctrl.set_flags)
			begin
				// flags from acc as it stands, seen by the next cond
				flags_q.z <= (o_acc == '0);
				flags_q.n <= o_acc[pat_pkg::data_width-1];
			end
		end
	end

	// write enable rides on decode's reset of the control word
	a_wr_en_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(o_wr_en));

endmodule

// ==== pat_core.sv ====
module pat_core (
	input logic clk,
	input logic reset,
	input pat_pkg::instr_u i_instruction,
	input pat_pkg::data_t i_inputs,
	output pat_pkg::data_t o_acc,
	output pat_pkg::data_t o_outputs
);

	logic [pat_pkg::dmem_adr_width-1:0] dmem_rd_adr;
	pat_pkg::data_t dmem_rd_data;
	pat_pkg::ctrl_t ctrl; // decode -> execute
	pat_pkg::data_t alu_y;
	logic wr_en; // commit -> memory write port
	logic [pat_pkg::dmem_adr_width-1:0] wr_adr;
	pat_pkg::data_t wr_data;

	// ==============================
	// stage 1, decode + mem read
	// ==============================
	pat_decode decode_i (
		.clk(clk),
		.reset(reset),
		.i_instruction(i_instruction),
		.o_dmem_adr(dmem_rd_adr),
		.i_dmem_data(dmem_rd_data),
		.o_ctrl(ctrl)
	);

	pat_data_mem dmem_i (
		.clk(clk),
		.i_rd_adr(dmem_rd_adr),
		.o_rd_data(dmem_rd_data),
		.i_wr_en(wr_en),
		.i_wr_adr(wr_adr),
		.i_wr_data(wr_data)
	);

	// ==============================
	// stage 2, execute + commit
	// ==============================
	pat_alu alu_i (
		.i_fn(ctrl.alu_fn),
		.i_a(o_acc), // committed acc, no forwarding needed
		.i_b(ctrl.operand_b),
		.o_y(alu_y)
	);

	pat_commit commit_i (
		.clk(clk),
		.reset(reset),
		.i_ctrl(ctrl),
		.i_alu_y(alu_y),
		.i_inputs(i_inputs),
		.o_acc(o_acc),
		.o_outputs(o_outputs),
		.o_wr_en(wr_en),
		.o_wr_adr(wr_adr),
		.o_wr_data(wr_data)
	);

endmodule

// ==== tb_pat_table.svh ====
// columns: instruction, i_inputs for the row, expected o_acc, expected o_outputs
// cond 2'b11 and 2'b10 always run, 2'b00 needs z, 2'b01 needs n
function automatic void fill_table();
	// reset state holds through nops
	add_row(enc_i0(2'b11, pat_pkg::op0_nop), 8'h00, 8'h00, 8'h00);
	add_row(enc_i0(2'b11, pat_pkg::op0_nop), 8'h00, 8'h00, 8'h00);
	// ==============================
	// logic and arithmetic, back to back
	// ==============================
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'h5a), 8'h00, 8'h5a, 8'h00);
	add_row(enc_i8(2'b11, pat_pkg::op8_add, 8'hc0), 8'h00, 8'h1a, 8'h00); // carry out lost
	add_row(enc_i8(2'b11, pat_pkg::op8_add, 8'hf0), 8'h00, 8'h0a, 8'h00);
	add_row(enc_i8(2'b11, pat_pkg::op8_sub, 8'h0c), 8'h00, 8'hfe, 8'h00); // borrow wraps
	add_row(enc_i8(2'b11, pat_pkg::op8_or, 8'h01), 8'h00, 8'hff, 8'h00);
	add_row(enc_i8(2'b11, pat_pkg::op8_and, 8'h3c), 8'h00, 8'h3c, 8'h00);
	add_row(enc_i0(2'b11, pat_pkg::op0_not), 8'h00, 8'hc3, 8'h00);
	add_row(enc_i3(2'b11, pat_pkg::op3_out, 3'd0), 8'h00, 8'hc3, 8'hc3);
	// shifts, distances 0 to 7 all appear
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'h96), 8'h00, 8'h96, 8'hc3);
	add_row(enc_i3(2'b11, pat_pkg::op3_shl, 3'd0), 8'h00, 8'h96, 8'hc3);
	add_row(enc_i3(2'b11, pat_pkg::op3_shl, 3'd3), 8'h00, 8'hb0, 8'hc3);
	add_row(enc_i3(2'b11, pat_pkg::op3_shlo, 3'd2), 8'h00, 8'hc3, 8'hc3); // ones in
	add_row(enc_i3(2'b11, pat_pkg::op3_shr, 3'd1), 8'h00, 8'h61, 8'hc3);
	add_row(enc_i3(2'b11, pat_pkg::op3_shlo, 3'd7), 8'h00, 8'hff, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'h96), 8'h00, 8'h96, 8'hc3);
	add_row(enc_i3(2'b11, pat_pkg::op3_asr, 3'd2), 8'h00, 8'he5, 8'hc3); // sign kept
	add_row(enc_i3(2'b11, pat_pkg::op3_asr, 3'd7), 8'h00, 8'hff, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'h70), 8'h00, 8'h70, 8'hc3);
	add_row(enc_i3(2'b11, pat_pkg::op3_asr, 3'd4), 8'h00, 8'h07, 8'hc3); // positive, zeros in
	add_row(enc_i3(2'b11, pat_pkg::op3_shr, 3'd7), 8'h00, 8'h00, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'h80), 8'h00, 8'h80, 8'hc3);
	add_row(enc_i3(2'b11, pat_pkg::op3_shr, 3'd5), 8'h00, 8'h04, 8'hc3);
	add_row(enc_i3(2'b11, pat_pkg::op3_shlo, 3'd5), 8'h00, 8'h9f, 8'hc3);
	add_row(enc_i3(2'b11, pat_pkg::op3_shl, 3'd6), 8'h00, 8'hc0, 8'hc3);
	add_row(enc_i3(2'b11, pat_pkg::op3_asr, 3'd1), 8'h00, 8'he0, 8'hc3);
	// ==============================
	// data memory
	// ==============================
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'h3c), 8'h00, 8'h3c, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_stm, 8'h05), 8'h00, 8'h3c, 8'hc3); // mem[5] = 3c
	add_row(enc_i0(2'b11, pat_pkg::op0_nop), 8'h00, 8'h3c, 8'hc3); // gap, write lands
	add_row(enc_i8(2'b11, pat_pkg::op8_addm, 8'h05), 8'h00, 8'h78, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_ldm, 8'h05), 8'h00, 8'h3c, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'ha5), 8'h00, 8'ha5, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_stm, 8'h09), 8'h00, 8'ha5, 8'hc3); // mem[9] = a5
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'h0f), 8'h00, 8'h0f, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_subm, 8'h09), 8'h00, 8'h6a, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_orm, 8'h05), 8'h00, 8'h7e, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_andm, 8'h09), 8'h00, 8'h24, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'h77), 8'h00, 8'h77, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_stm, 8'h09), 8'h00, 8'h77, 8'hc3);
	add_row(enc_i8(2'b11, pat_pkg::op8_ldm, 8'h09), 8'h00, 8'ha5, 8'hc3); // right after stm
	add_row(enc_i8(2'b11, pat_pkg::op8_ldm, 8'h09), 8'h00, 8'h77, 8'hc3);
	// in and out
	add_row(enc_i3(2'b11, pat_pkg::op3_in, 3'd0), 8'h42, 8'h42, 8'hc3);
	add_row(enc_i3(2'b11, pat_pkg::op3_out, 3'd0), 8'h00, 8'h42, 8'h42);
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'h01), 8'h00, 8'h01, 8'h42); // outputs held
	add_row(enc_i3(2'b11, pat_pkg::op3_in, 3'd0), 8'he7, 8'he7, 8'h42);
	add_row(enc_i3(2'b11, pat_pkg::op3_out, 3'd0), 8'h00, 8'he7, 8'he7);
	// ==============================
	// conditions and flags
	// ==============================
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'h00), 8'h00, 8'h00, 8'he7);
	add_row(enc_i0(2'b11, pat_pkg::op0_test), 8'h00, 8'h00, 8'he7); // z set
	add_row(enc_i8(2'b00, pat_pkg::op8_ldi, 8'h11), 8'h00, 8'h11, 8'he7);
	add_row(enc_i0(2'b11, pat_pkg::op0_test), 8'h00, 8'h11, 8'he7); // z and n clear
	add_row(enc_i8(2'b00, pat_pkg::op8_ldi, 8'h22), 8'h00, 8'h11, 8'he7); // skipped
	add_row(enc_i8(2'b01, pat_pkg::op8_ldi, 8'h33), 8'h00, 8'h11, 8'he7); // skipped
	add_row(enc_i3(2'b00, pat_pkg::op3_out, 3'd0), 8'h00, 8'h11, 8'he7); // skipped
	add_row(enc_i8(2'b11, pat_pkg::op8_ldi, 8'h90), 8'h00, 8'h90, 8'he7);
	add_row(enc_i0(2'b11, pat_pkg::op0_test), 8'h00, 8'h90, 8'he7); // n set
	add_row(enc_i8(2'b01, pat_pkg::op8_add, 8'h01), 8'h00, 8'h91, 8'he7);
	add_row(enc_i3(2'b01, pat_pkg::op3_out, 3'd0), 8'h00, 8'h91, 8'h91);
	add_row(enc_i0(2'b00, pat_pkg::op0_not), 8'h00, 8'h91, 8'h91); // skipped
	add_row(enc_i8(2'b00, pat_pkg::op8_stm, 8'h05), 8'h00, 8'h91, 8'h91); // no write
	add_row(enc_i0(2'b11, pat_pkg::op0_nop), 8'h00, 8'h91, 8'h91);
	add_row(enc_i8(2'b11, pat_pkg::op8_ldm, 8'h05), 8'h00, 8'h3c, 8'h91); // old word kept
	add_row(enc_i8(2'b10, pat_pkg::op8_ldi, 8'h5a), 8'h00, 8'h5a, 8'h91);
	// tail of nops, state must hold
	add_row(enc_i0(2'b11, pat_pkg::op0_nop), 8'h00, 8'h5a, 8'h91);
	add_row(enc_i0(2'b11, pat_pkg::op0_nop), 8'h00, 8'h5a, 8'h91);
endfunction

// ==== tb_pat.sv ====
module tb_pat;

	timeunit 1ns;
	timeprecision 1ps;

	// one table row, expected values are the state after its commit
	typedef struct packed {
		pat_pkg::instr_u instr;
		pat_pkg::data_t in_val; // i_inputs while this row commits
		pat_pkg::data_t exp_acc;
		pat_pkg::data_t exp_out;
	} row_t;

	logic clk;
	logic reset;
	pat_pkg::instr_u i_instruction;
	pat_pkg::data_t i_inputs;
	pat_pkg::data_t o_acc;
	pat_pkg::data_t o_outputs;

	row_t rows[$]; // filled by fill_table
	int errors;
	int checks;
	bit released; // reset seen low in time

	pat_core dut_i (
		.clk(clk),
		.reset(reset),
		.i_instruction(i_instruction),
		.i_inputs(i_inputs),
		.o_acc(o_acc),
		.o_outputs(o_outputs)
	);

	// ==============================
	// clock and reset
	// ==============================
	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk; // 100 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (10) @(posedge clk); // ten cycles in reset
		#1 reset = 1'b0; // off the edge like the other inputs
	end

	// ==============================
	// instruction encoders
	// ==============================
	function automatic pat_pkg::instr_u enc_i8(input logic [1:0] cond, input logic [3:0] op,
		input logic [7:0] imm);
		pat_pkg::instr_u w;
		w.i8.ptr = '0; // field pointer unused here
		w.i8.cond = cond;
		w.i8.field = 1'b0;
		w.i8.opcode = op;
		w.i8.imm8 = imm;
		return w;
	endfunction

	// i3: first prefix, sub-opcode, 3-bit immediate
	function automatic pat_pkg::instr_u enc_i3(input logic [1:0] cond, input logic [3:0] op,
		input logic [2:0] imm3);
		pat_pkg::instr_u w;
		w = enc_i8(cond, pat_pkg::prefix_ext, 8'h00);
		w.ext.opcode_i3 = op;
		w.ext.low = {1'b0, imm3};
		return w;
	endfunction

	// i0: both prefixes, then the opcode in the low nibble
	function automatic pat_pkg::instr_u enc_i0(input logic [1:0] cond, input logic [3:0] op);
		pat_pkg::instr_u w;
		w = enc_i8(cond, pat_pkg::prefix_ext, 8'h00);
		w.ext.opcode_i3 = pat_pkg::prefix_ext;
		w.ext.low = op;
		return w;
	endfunction

	function automatic void add_row(input pat_pkg::instr_u instr, input pat_pkg::data_t in_val,
		input pat_pkg::data_t exp_acc, input pat_pkg::data_t exp_out);
		row_t r;
		r.instr = instr;
		r.in_val = in_val;
		r.exp_acc = exp_acc;
		r.exp_out = exp_out;
		rows.push_back(r);
	endfunction

	`include "tb_pat_table.svh"

	// ==============================
	// checks and stimulus
	// ==============================
	task automatic check_data(input string what, input pat_pkg::data_t got,
		input pat_pkg::data_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at %0t: %s is %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic wait_reset_release(output bit ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < 40) // gives up after 40 cycles
		begin
			@(posedge clk);
			#2; // past the reset driver's 1 ns step
			cycles++;
			ok = (reset === 1'b0);
		end
	endtask

	task automatic run_table();
		int k;
		int n;
		n = rows.size();
		for (k = 0; k < n + 3; k++) // three extra steps drain the pipe
		begin
			@(posedge clk);
			#1;
			// row k-3 was sampled two edges ago and committed on this one
			if (k >= 3)
			begin
				check_data($sformatf("row %0d o_acc", k - 3), o_acc, rows[k-3].exp_acc);
				check_data($sformatf("row %0d o_outputs", k - 3), o_outputs, rows[k-3].exp_out);
			end
			if (k < n)
				i_instruction = rows[k].instr;
			else
				i_instruction = pat_pkg::instr_nop;
			// in picks up i_inputs in its commit cycle, two rows later
			if (k >= 2 && k - 2 < n)
				i_inputs = rows[k-2].in_val;
			else
				i_inputs = '0;
		end
	endtask

	initial
	begin
		$timeformat(-9, 0, " ns", 0);
		i_instruction = pat_pkg::instr_nop;
		i_inputs = '0;
		errors = 0;
		checks = 0;
		wait_reset_release(released);
		if (released)
		begin
			check_data("o_acc after reset", o_acc, '0);
			check_data("o_outputs after reset", o_outputs, '0);
			fill_table();
			run_table();
		end
		else
		begin
			errors++;
			$display("timeout: reset was still high after 40 clock cycles");
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+.
pat_pkg.sv
pat_decode.sv
pat_data_mem.sv
pat_alu.sv
pat_commit.sv
pat_core.sv
tb_pat.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --assert --timescale 1ns/1ps
TOP ?= tb_pat
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
